//--- build.f
hw/mci_pkg.sv
hw/mci_axil_slave.sv
hw/mci_reg_bank.sv
hw/mci_rsp_merge.sv
hw/mci_reg_top.sv
+incdir+dv
dv/mci_tb.sv

//--- dv/mci_tb_model.svh
/*
 * Reference model for the register subsystem testbench
 * Register array, sticky locks, response rules and the xorshift source
 * Included inside the testbench module body
 */

// Model state, carried across tests
logic [mci_pkg::DATA_WIDTH-1:0] m_regs [mci_pkg::NUM_BANKS][mci_pkg::REGS_PER_BANK];
logic [mci_pkg::NUM_BANKS-1:0]  m_lock;
logic [31:0]                    rng_state = 32'd17;   // Fixed seed

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic void model_reset();
    for (int b = 0; b < mci_pkg::NUM_BANKS; b++) begin
        for (int r = 0; r < mci_pkg::REGS_PER_BANK; r++) begin
            m_regs[b][r] = '0;
        end
    end
    m_lock = '0;
endfunction

// One byte of ones per strobe
function automatic logic [31:0] strb_mask(input logic [3:0] strb);
    logic [31:0] mask;
    for (int i = 0; i < 4; i++) begin
        mask[i*8 +: 8] = {8{strb[i]}};
    end
    return mask;
endfunction

// Applies a write, returns the expected BRESP
function automatic logic [1:0] model_write(input logic [7:0] addr, input logic [31:0] data,
                                           input logic [3:0] strb);
    logic [31:0] mask;
    int          bank;
    int          idx;
    mask = strb_mask(strb);
    bank = addr[6:5];
    idx  = addr[4:2];
    if (addr[7]) begin
        return mci_pkg::RESP_SLVERR;                 // Outside the window
    end
    if (idx != 0 && m_lock[bank]) begin
        return mci_pkg::RESP_SLVERR;                 // Locked scratch
    end
    m_regs[bank][idx] = (m_regs[bank][idx] & ~mask) | (data & mask);
    if (idx == 0) begin
        // Lock only ever sets
        m_regs[bank][0][mci_pkg::LOCK_BIT] = m_regs[bank][0][mci_pkg::LOCK_BIT] | m_lock[bank];
        m_lock[bank] = m_regs[bank][0][mci_pkg::LOCK_BIT];
    end
    return mci_pkg::RESP_OKAY;
endfunction

// Expected RRESP and RDATA, zero data on error
function automatic void model_read(input logic [7:0] addr, output logic [1:0] resp,
                                   output logic [31:0] data);
    resp = addr[7] ? mci_pkg::RESP_SLVERR : mci_pkg::RESP_OKAY;
    data = addr[7] ? '0 : m_regs[addr[6:5]][addr[4:2]];
endfunction

//--- dv/mci_tb.sv
`timescale 1ns/1ps

/*
 * Testbench for the register subsystem top
 * Random AXI4-Lite traffic from xorshift, checked against the included model
 * Covers reset values, strobes, locks, decode errors, back-pressure and latency
 */
module mci_tb;

    localparam int N_RESET   = 32;                   // Every in-range word
    localparam int N_STRB    = 200;
    localparam int N_LOCK    = 40;
    localparam int N_OOR     = 40;
    localparam int N_BP      = 60;
    localparam int TOTAL_TXN = N_RESET + 2 * N_STRB + 1 + 2 * N_LOCK + N_OOR + N_BP;

    logic        clk;
    logic        arst_n;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [7:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb, bank_lock;
    logic [1:0]  bresp, rresp;

    int cyc = 0;                                     // Rising edges so far
    int test_err = 0;
    int n_checks = 0;
    int lat_err = 0;
    int err_total = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "mci_tb_model.svh"

    mci_reg_top i_dut (.*);

    //////////////////////////////
    // Clock, edge count, watchdog
    //////////////////////////////
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        repeat (TOTAL_TXN * 40) @(posedge clk);
        $display("Watchdog expired: transactions stopped completing after %0d cycles", cyc);
        $display("test failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
        n_checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, what, exp, got);
            test_err++;
        end
    endtask

    //////////////////////////////
    // Bus driver
    //////////////////////////////

    // One access with ready held low for stall cycles after valid
    task automatic run_access(input bit wr, input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int stall,
                              output logic [1:0] resp, output logic [31:0] rd);
        int hs_edge;
        @(posedge clk);
        if (wr) begin
            awvalid <= 1'b1;
            awaddr  <= addr;
            wvalid  <= 1'b1;
            wdata   <= data;
            wstrb   <= strb;
        end else begin
            arvalid <= 1'b1;
            araddr  <= addr;
        end
        bready <= (stall == 0);
        rready <= (stall == 0);
        @(negedge clk);
        assert (wr ? (awready && wready) : arready) else begin
            $display("Idle slave did not accept the request at %0t", $time);
            test_err++;
        end
        hs_edge = cyc + 1;                           // Handshake on the coming edge
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
        @(negedge clk);
        while (!(wr ? bvalid : rvalid)) @(negedge clk);
        assert (cyc - hs_edge == 2) else begin
            $display("Mismatch at %0t: response after %0d edges, expected 2",
                     $time, cyc - hs_edge);
            lat_err++;
        end
        resp = wr ? bresp : rresp;
        rd   = rdata;
        repeat (stall) begin
            @(posedge clk);
            if (wr) begin
                arvalid <= 1'b1;                     // Competing read that must wait
                araddr  <= addr;
            end else begin
                awvalid <= 1'b1;                     // Competing write that must wait
                wvalid  <= 1'b1;
                awaddr  <= addr;
            end
            @(negedge clk);
            assert ((wr ? bvalid : rvalid) && (wr ? bresp : rresp) == resp
                    && (wr || rdata == rd)) else begin
                $display("Mismatch at %0t: response changed under back-pressure", $time);
                test_err++;
            end
            assert (!arready && !awready && !wready) else begin
                $display("A second request was accepted while a response waited at %0t", $time);
                test_err++;
            end
        end
        if (stall > 0) begin
            @(posedge clk);
            bready  <= 1'b1;
            rready  <= 1'b1;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end
    endtask

    task automatic checked_write(input logic [7:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb, input int stall);
        logic [1:0]  resp;
        logic [31:0] rd;
        run_access(1'b1, addr, data, strb, stall, resp, rd);
        check_value("bresp", 32'(model_write(addr, data, strb)), 32'(resp));
    endtask

    task automatic checked_read(input logic [7:0] addr, input int stall);
        logic [1:0]  resp, exp_resp;
        logic [31:0] rd, exp_data;
        run_access(1'b0, addr, '0, '0, stall, resp, rd);
        model_read(addr, exp_resp, exp_data);
        check_value("rresp", 32'(exp_resp), 32'(resp));
        check_value("rdata", exp_data, rd);
    endtask

    task automatic end_test(input string name);
        if (test_err == 0) $display("%s: ok, %0d checks", name, n_checks);
        else $display("%s: FAILED, %0d errors in %0d checks", name, test_err, n_checks);
        err_total += test_err;
        tests_failed += (test_err != 0);
        tests_run++;
        test_err = 0;
        n_checks = 0;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    initial begin
        logic [31:0] r;
        logic [1:0]  lb;
        arst_n = 1'b0;
        {awvalid, wvalid, arvalid, bready, rready} = '0;
        {awaddr, araddr, wdata, wstrb} = '0;
        model_reset();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        for (int a = 0; a < N_RESET * 4; a += 4) checked_read(8'(a), 0);
        check_value("bank_lock", 32'(m_lock), 32'(bank_lock));
        end_test("reset values");

        for (int i = 0; i < N_STRB; i++) begin
            r = xorshift32();                        // Bank, scratch index, byte bits
            checked_write({1'b0, r[1:0], 3'(1 + r[10:8] % 7), r[13:12]}, xorshift32(),
                          r[19:16], 0);
            checked_read({1'b0, r[1:0], 3'(1 + r[10:8] % 7), 2'b00}, 0);
        end
        end_test("strobed writes");

        lb = 2'(xorshift32());
        checked_write({1'b0, lb, 5'b0}, 32'h1, 4'b0001, 0);
        check_value("bank_lock", 32'(m_lock), 32'(bank_lock));
        for (int i = 0; i < N_LOCK; i++) begin
            r = xorshift32();
            checked_write({1'b0, r[1:0], 3'(1 + r[10:8] % 7), 2'b00}, xorshift32(), r[19:16], 0);
            checked_read({1'b0, r[1:0], 3'(1 + r[10:8] % 7), 2'b00}, 0);
        end
        check_value("bank_lock", 32'(m_lock), 32'(bank_lock));
        end_test("lock behavior");

        for (int i = 0; i < N_OOR; i++) begin
            r = xorshift32();
            if (r[8]) checked_write({1'b1, r[6:0]}, xorshift32(), r[19:16], 0);
            else checked_read({1'b1, r[6:0]}, 0);
        end
        end_test("out-of-range addresses");

        for (int i = 0; i < N_BP; i++) begin
            r = xorshift32();                        // Mostly in range with a random stall
            if (r[16]) checked_write({r[20] & r[21], r[6:0]}, xorshift32(), r[11:8], r[26:24] % 6);
            else checked_read({r[20] & r[21], r[6:0]}, r[26:24] % 6);
        end
        end_test("back-pressure");

        test_err = lat_err;
        n_checks = TOTAL_TXN;
        end_test("fixed latency");

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- hw/mci_axil_slave.sv
`timescale 1ns/1ps

/*
 * AXI4-Lite slave in front of the register banks
 * Accepts one request at a time, a write wins over a read in the same cycle
 * Issues a one-cycle request pulse and holds the B or R response until taken
 */
module mci_axil_slave (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // Write address
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]        awaddr,
    // Write data
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [mci_pkg::DATA_WIDTH-1:0]        wdata,
    input  logic [mci_pkg::STRB_WIDTH-1:0]        wstrb,
    // Write response
    output logic                                  bvalid,
    input  logic                                  bready,
    output logic [1:0]                            bresp,
    // Read address
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]        araddr,
    // Read data
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [mci_pkg::DATA_WIDTH-1:0]        rdata,
    output logic [1:0]                            rresp,

    // Request to the banks
    output logic                                  req_valid,
    output logic                                  req_wr,
    output logic [mci_pkg::REG_IDX_WIDTH-1:0]     req_reg,
    output logic [mci_pkg::DATA_WIDTH-1:0]        req_wdata,
    output logic [mci_pkg::DATA_WIDTH-1:0]        req_biten,
    output logic [mci_pkg::NUM_BANKS-1:0]         req_sel,

    // Response from the merger
    input  logic                                  rsp_valid,
    input  logic                                  rsp_wr,
    input  logic [mci_pkg::DATA_WIDTH-1:0]        rsp_rdata,
    input  logic                                  rsp_err
);

    logic                              busy;       // Request sent, response not back yet
    logic                              idle;
    logic                              wr_hs;      // AW and W taken this edge
    logic                              rd_hs;      // AR taken this edge
    mci_pkg::addr_u                    dec_addr;
    logic [mci_pkg::NUM_BANKS-1:0]     dec_sel;
    logic [mci_pkg::DATA_WIDTH-1:0]    dec_biten;
    logic [1:0]                        rsp_code;

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    // New work only with nothing in flight and nothing waiting on the host
    assign idle    = ~busy & ~bvalid & ~rvalid;
    assign awready = idle & awvalid & wvalid;        // AW and W go as a pair
    assign wready  = awready;
    assign arready = idle & arvalid & ~(awvalid & wvalid); // Write has priority
    assign wr_hs   = awvalid & awready;
    assign rd_hs   = arvalid & arready;

    //////////////////////////////
    // Decode
    //////////////////////////////
    assign dec_addr.offset = wr_hs ? awaddr : araddr;

    always_comb begin
        dec_sel = '0;
        if (!dec_addr.f.oor) begin
            dec_sel[dec_addr.f.bank] = 1'b1;          // One-hot bank
        end
    end

    // Byte strobes widened to bit enables
    for (genvar i = 0; i < mci_pkg::DATA_WIDTH; i++) begin : g_biten
        assign dec_biten[i] = wstrb[i / (mci_pkg::DATA_WIDTH / mci_pkg::STRB_WIDTH)];
    end

    //////////////////////////////
    // Request issue
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            req_valid <= 1'b0;
            req_wr    <= 1'b0;
            req_sel   <= '0;
        end else begin
            req_valid <= wr_hs | rd_hs;              // Single-cycle pulse
            if (wr_hs || rd_hs) begin
                busy    <= 1'b1;
                req_wr  <= wr_hs;
                req_sel <= dec_sel;
            end else if (rsp_valid) begin
                busy <= 1'b0;                        // Response now sits in B or R
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (wr_hs || rd_hs) begin
            req_reg   <= dec_addr.f.reg_idx;
            req_wdata <= wdata;
            req_biten <= wr_hs ? dec_biten : '0;     // Reads enable nothing
        end
    end

    //////////////////////////////
    // Response hold
    //////////////////////////////
    assign rsp_code = rsp_err ? mci_pkg::RESP_SLVERR : mci_pkg::RESP_OKAY;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (rsp_valid && rsp_wr) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rsp_valid && !rsp_wr) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid && rsp_wr) begin
            bresp <= rsp_code;
        end
        if (rsp_valid && !rsp_wr) begin
            rresp <= rsp_code;
            rdata <= rsp_rdata;                      // Already zero on error
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    a_single_rsp : assert property (@(posedge clk) disable iff (!arst_n)
        !(bvalid && rvalid));

    // Held under back-pressure
    a_b_hold : assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));
    a_r_hold : assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

    a_sel_onehot : assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> $onehot0(req_sel));

endmodule

//--- hw/mci_pkg.sv
/*
 * Shared definitions for the management-control register subsystem
 * Geometry of the banks, AXI response codes and the address word layout
 * Every RTL file refers to these by scoped name
 */
package mci_pkg;

    //////////////////////////////
    // Bus geometry
    //////////////////////////////
    localparam int DATA_WIDTH = 32;                 // Data word
    localparam int STRB_WIDTH = DATA_WIDTH / 8;     // One strobe per byte
    localparam int ADDR_WIDTH = 8;                  // AXI byte address

    //////////////////////////////
    // Bank geometry
    //////////////////////////////
    localparam int NUM_BANKS     = 4;
    localparam int BANK_WIDTH    = $clog2(NUM_BANKS);
    localparam int REGS_PER_BANK = 8;               // Control plus seven scratch
    localparam int REG_IDX_WIDTH = $clog2(REGS_PER_BANK);
    localparam int BYTE_WIDTH    = $clog2(STRB_WIDTH);

    localparam int CTRL_REG = 0;                    // Register index of the control word
    localparam int LOCK_BIT = 0;                    // Sticky lock inside the control word

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    //////////////////////////////
    // Address word
    //////////////////////////////

    // Field view of a request address
    typedef struct packed {
        logic                     oor;      // Above the mapped window
        logic [BANK_WIDTH-1:0]    bank;     // Bank select
        logic [REG_IDX_WIDTH-1:0] reg_idx;  // Register within the bank
        logic [BYTE_WIDTH-1:0]    byte_off; // Byte lane, ignored by the banks
    } addr_fields_t;

    // Same address word, flat or split into fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] offset;      // Raw byte offset from the bus
        addr_fields_t          f;
    } addr_u;

endpackage

//--- hw/mci_reg_bank.sv
`timescale 1ns/1ps

/*
 * One lockable scratch-register bank
 * Register 0 is control with a sticky lock, registers 1 to 7 are scratch
 * Locked banks refuse scratch writes with an error until reset
 */
module mci_reg_bank (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // Shared request
    input  logic                                  req_valid,
    input  logic                                  req_wr,
    input  logic [mci_pkg::REG_IDX_WIDTH-1:0]     req_reg,
    input  logic [mci_pkg::DATA_WIDTH-1:0]        req_wdata,
    input  logic [mci_pkg::DATA_WIDTH-1:0]        req_biten,
    input  logic                                  sel,        // This bank addressed

    // Per-bank results
    output logic [mci_pkg::DATA_WIDTH-1:0]        rdata,
    output logic                                  wr_err,
    output logic                                  lock
);

    // Register file
    logic [mci_pkg::DATA_WIDTH-1:0] regs [mci_pkg::REGS_PER_BANK];

    logic                           wr_en;        // Selected write this cycle
    logic                           scratch_tgt;  // Target is not the control word
    logic [mci_pkg::DATA_WIDTH-1:0] wr_word;      // Value after bit-enable merge

    //////////////////////////////
    // Access decode
    //////////////////////////////
    assign wr_en       = req_valid & sel & req_wr;
    assign scratch_tgt = (req_reg != mci_pkg::REG_IDX_WIDTH'(mci_pkg::CTRL_REG));

    // Control writes always pass
    assign wr_err = wr_en & scratch_tgt & lock;

    // Lock lives in the control word
    assign lock = regs[mci_pkg::CTRL_REG][mci_pkg::LOCK_BIT];

    // Read path
    assign rdata = regs[req_reg];                 // Plain index that the merger qualifies

    //////////////////////////////
    // Write merge
    //////////////////////////////
    always_comb begin
        // Keep bits that are not enabled
        wr_word = (regs[req_reg] & ~req_biten) | (req_wdata & req_biten);
        if (!scratch_tgt) begin
            // Lock only sets, never clears
            wr_word[mci_pkg::LOCK_BIT] = wr_word[mci_pkg::LOCK_BIT] | lock;
        end
    end

    //////////////////////////////
    // Storage
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < mci_pkg::REGS_PER_BANK; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en && !wr_err) begin
            regs[req_reg] <= wr_word;             // Refused writes leave data as is
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Sticky until reset
    a_lock_sticky : assert property (@(posedge clk) disable iff (!arst_n)
        lock |=> lock);

endmodule

//--- hw/mci_reg_top.sv
`timescale 1ns/1ps

/*
 * Top of the management-control register subsystem
 * AXI4-Lite slave feeds a row of lockable scratch banks, the merger drains them
 * bank_lock shows the sticky lock of every bank
 */
module mci_reg_top (
    input  logic                              clk,
    input  logic                              arst_n,

    // AXI4-Lite write address
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]    awaddr,
    // AXI4-Lite write data
    input  logic                              wvalid,
    output logic                              wready,
    input  logic [mci_pkg::DATA_WIDTH-1:0]    wdata,
    input  logic [mci_pkg::STRB_WIDTH-1:0]    wstrb,
    // AXI4-Lite write response
    output logic                              bvalid,
    input  logic                              bready,
    output logic [1:0]                        bresp,
    // AXI4-Lite read address
    input  logic                              arvalid,
    output logic                              arready,
    input  logic [mci_pkg::ADDR_WIDTH-1:0]    araddr,
    // AXI4-Lite read data
    output logic                              rvalid,
    input  logic                              rready,
    output logic [mci_pkg::DATA_WIDTH-1:0]    rdata,
    output logic [1:0]                        rresp,

    // Lock status per bank
    output logic [mci_pkg::NUM_BANKS-1:0]     bank_lock
);

    // Request fan-out
    logic                                                   req_valid;
    logic                                                   req_wr;
    logic [mci_pkg::REG_IDX_WIDTH-1:0]                      req_reg;
    logic [mci_pkg::DATA_WIDTH-1:0]                         req_wdata;
    logic [mci_pkg::DATA_WIDTH-1:0]                         req_biten;
    logic [mci_pkg::NUM_BANKS-1:0]                          req_sel;

    // Bank results
    logic [mci_pkg::NUM_BANKS-1:0][mci_pkg::DATA_WIDTH-1:0] bank_rdata;
    logic [mci_pkg::NUM_BANKS-1:0]                          bank_wr_err;

    // Merged response
    logic                                                   rsp_valid;
    logic                                                   rsp_wr;
    logic [mci_pkg::DATA_WIDTH-1:0]                         rsp_rdata;
    logic                                                   rsp_err;

    //////////////////////////////
    // Bus front end
    //////////////////////////////
    mci_axil_slave i_axil_slave (
        .clk        (clk),
        .arst_n     (arst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .req_valid  (req_valid),
        .req_wr     (req_wr),
        .req_reg    (req_reg),
        .req_wdata  (req_wdata),
        .req_biten  (req_biten),
        .req_sel    (req_sel),
        .rsp_valid  (rsp_valid),
        .rsp_wr     (rsp_wr),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err)
    );

    //////////////////////////////
    // Banks
    //////////////////////////////
    for (genvar b = 0; b < mci_pkg::NUM_BANKS; b++) begin : g_bank
        mci_reg_bank i_bank (
            .clk        (clk),
            .arst_n     (arst_n),
            .req_valid  (req_valid),
            .req_wr     (req_wr),
            .req_reg    (req_reg),
            .req_wdata  (req_wdata),
            .req_biten  (req_biten),
            .sel        (req_sel[b]),        // Own select bit only
            .rdata      (bank_rdata[b]),
            .wr_err     (bank_wr_err[b]),
            .lock       (bank_lock[b])
        );
    end

    //////////////////////////////
    // Response drain
    //////////////////////////////
    mci_rsp_merge i_rsp_merge (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_wr       (req_wr),
        .req_sel      (req_sel),
        .bank_rdata   (bank_rdata),
        .bank_wr_err  (bank_wr_err),
        .rsp_valid    (rsp_valid),
        .rsp_wr       (rsp_wr),
        .rsp_rdata    (rsp_rdata),
        .rsp_err      (rsp_err)
    );

endmodule

//--- hw/mci_rsp_merge.sv
`timescale 1ns/1ps

/*
 * Response drain for the register banks
 * Picks the addressed bank's read data and error by the one-hot select
 * Registers one response per request, one cycle after the request pulse
 */
module mci_rsp_merge (
    input  logic                                                     clk,
    input  logic                                                     arst_n,

    // Request as seen by the banks
    input  logic                                                     req_valid,
    input  logic                                                     req_wr,
    input  logic [mci_pkg::NUM_BANKS-1:0]                            req_sel,

    // Bank results
    input  logic [mci_pkg::NUM_BANKS-1:0][mci_pkg::DATA_WIDTH-1:0]   bank_rdata,
    input  logic [mci_pkg::NUM_BANKS-1:0]                            bank_wr_err,

    // Registered response
    output logic                                                     rsp_valid,
    output logic                                                     rsp_wr,
    output logic [mci_pkg::DATA_WIDTH-1:0]                           rsp_rdata,
    output logic                                                     rsp_err
);

    logic [mci_pkg::DATA_WIDTH-1:0] sel_rdata;
    logic                           sel_err;
    logic                           dec_err;      // Address hit no bank
    logic                           err;

    // AND-OR mux over the one-hot select
    always_comb begin
        sel_rdata = '0;
        sel_err   = 1'b0;
        for (int b = 0; b < mci_pkg::NUM_BANKS; b++) begin
            if (req_sel[b]) begin
                sel_rdata = sel_rdata | bank_rdata[b];
                sel_err   = sel_err | bank_wr_err[b];
            end
        end
    end

    assign dec_err = ~|req_sel;
    assign err     = dec_err | sel_err;

    //////////////////////////////
    // Response register
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;               // One response per pulse
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_wr    <= req_wr;
            rsp_err   <= err;
            rsp_rdata <= err ? '0 : sel_rdata;    // No data leaks on error
        end
    end

    // Single request in flight upstream
    a_rsp_pulse : assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid);

endmodule
